// ==== hdl/arcade_io_pkg.sv ====
package arcade_io_pkg;

	localparam int ADDR_W    = 8;
	localparam int DATA_W    = 32;
	localparam int AUDIO_W   = 16;
	localparam int BUTTONS_W = 2;

	// host register map, byte addresses
	localparam logic [ADDR_W-1:0] REG_STATUS  = 8'h00;
	localparam logic [ADDR_W-1:0] REG_JOY     = 8'h04;
	localparam logic [ADDR_W-1:0] REG_BUTTONS = 8'h08;
	localparam logic [ADDR_W-1:0] REG_KEY     = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_CONTROL = 8'h10; // read only

	localparam int STATUS_RESET      = 0;
	localparam int STATUS_MENU_RESET = 6;
	localparam int BUTTON_RESET      = 1;

	// ps/2 set 2 scan codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_ESC   = 8'h76;
	localparam logic [7:0] KEY_F1    = 8'h05;
	localparam logic [7:0] KEY_F2    = 8'h06;
	localparam logic [7:0] KEY_CTRL  = 8'h14;
	localparam logic [7:0] KEY_ALT   = 8'h11;
	localparam logic [7:0] KEY_SPACE = 8'h29;

	typedef struct packed {
		logic       toggle;  // flips once per host event
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	// bit 0 is right, as in the host joystick byte
	typedef struct packed {
		logic [1:0] spare;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} key_state_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic coin;
		logic start1;
		logic start2;
	} control_t;

endpackage

// ==== hdl/host_regs.sv ====
`timescale 1ns/1ns

module host_regs (
	input  logic                                clk_20,
	input  logic                                reset,
	input  logic [arcade_io_pkg::ADDR_W-1:0]    paddr,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [arcade_io_pkg::DATA_W-1:0]    pwdata,
	output logic [arcade_io_pkg::DATA_W-1:0]    prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  arcade_io_pkg::control_t             control,
	output logic [arcade_io_pkg::DATA_W-1:0]    status,
	output arcade_io_pkg::joy_t                 joy0,
	output arcade_io_pkg::joy_t                 joy1,
	output logic [arcade_io_pkg::BUTTONS_W-1:0] buttons,
	output arcade_io_pkg::key_event_t           key_event
);
	import arcade_io_pkg::*;

	logic              access;
	logic              hit_status;
	logic              hit_joy;
	logic              hit_buttons;
	logic              hit_key;
	logic              hit_control;
	logic              bad_access;
	logic              wr_en;
	logic [DATA_W-1:0] rd_data;

	assign access      = psel & penable;
	assign hit_status  = (paddr == REG_STATUS);
	assign hit_joy     = (paddr == REG_JOY);
	assign hit_buttons = (paddr == REG_BUTTONS);
	assign hit_key     = (paddr == REG_KEY);
	assign hit_control = (paddr == REG_CONTROL);

	// unmapped, or a write to the read-only word
	assign bad_access = ~(hit_status | hit_joy | hit_buttons | hit_key | hit_control)
		| (pwrite & hit_control);
	assign wr_en      = access & pwrite & ~bad_access;

	assign pready  = 1'b1; // no wait states
	assign pslverr = access & bad_access;
	assign prdata  = access ? rd_data : '0;

	always_comb begin
		case (paddr)
			REG_STATUS:  rd_data = status;
			REG_JOY:     rd_data = {16'h0000, joy1, joy0};
			REG_BUTTONS: rd_data = DATA_W'(buttons);
			REG_KEY:     rd_data = DATA_W'(key_event);
			REG_CONTROL: rd_data = DATA_W'(control);
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_20) begin
		if (reset) begin
			status    <= '0;
			joy0      <= '0;
			joy1      <= '0;
			buttons   <= '0;
			key_event <= '0;
		end else if (wr_en) begin
			if (hit_status)
				status <= pwdata;
			if (hit_joy) begin
				joy0 <= joy_t'(pwdata[7:0]);
				joy1 <= joy_t'(pwdata[15:8]);
			end
			if (hit_buttons)
				buttons <= pwdata[BUTTONS_W-1:0];
			if (hit_key) begin
				key_event.toggle  <= ~key_event.toggle; // marks a new event
				key_event.pressed <= pwdata[8];
				key_event.code    <= pwdata[7:0];
			end
		end
	end

endmodule

// ==== hdl/key_decode.sv ====
`timescale 1ns/1ns

module key_decode (
	input  logic                      clk_20,
	input  logic                      reset,
	input  arcade_io_pkg::key_event_t key_event,
	output arcade_io_pkg::key_state_t key_state
);
	import arcade_io_pkg::*;

	logic toggle_last;
	logic new_event;

	assign new_event = (key_event.toggle != toggle_last);

	always_ff @(posedge clk_20) begin
		if (reset)
			toggle_last <= 1'b0;
		else
			toggle_last <= key_event.toggle;
	end

	always_ff @(posedge clk_20) begin
		if (reset) begin
			key_state <= '0;
		end else if (new_event) begin
			case (key_event.code)
				KEY_UP:
					key_state.up <= key_event.pressed;
				KEY_DOWN:
					key_state.down <= key_event.pressed;
				KEY_LEFT:
					key_state.left <= key_event.pressed;
				KEY_RIGHT:
					key_state.right <= key_event.pressed;
				KEY_ESC:
					key_state.coin <= key_event.pressed;
				KEY_F1:
					key_state.start1 <= key_event.pressed;
				KEY_F2:
					key_state.start2 <= key_event.pressed;
				KEY_SPACE:
					key_state.fire1 <= key_event.pressed;
				KEY_ALT:
					key_state.fire2 <= key_event.pressed;
				KEY_CTRL:
					key_state.fire3 <= key_event.pressed;
				default: ; // other codes ignored
			endcase
		end
	end

endmodule

// ==== hdl/control_merge.sv ====
`timescale 1ns/1ns

module control_merge (
	input  logic                                clk_20,
	input  logic                                reset,
	input  arcade_io_pkg::key_state_t           key_state,
	input  arcade_io_pkg::joy_t                 joy0,
	input  arcade_io_pkg::joy_t                 joy1,
	input  logic [arcade_io_pkg::DATA_W-1:0]    status,
	input  logic [arcade_io_pkg::BUTTONS_W-1:0] buttons,
	output arcade_io_pkg::control_t             control,
	output logic                                game_reset
);
	import arcade_io_pkg::*;

	joy_t     joy0_q;
	joy_t     joy1_q;
	logic     host_rst_q;
	control_t control_next;

	// host inputs staged to line up with the key decode register
	always_ff @(posedge clk_20) begin
		if (reset) begin
			joy0_q     <= '0;
			joy1_q     <= '0;
			host_rst_q <= 1'b0;
		end else begin
			joy0_q     <= joy0;
			joy1_q     <= joy1;
			host_rst_q <= status[STATUS_RESET] | status[STATUS_MENU_RESET]
				| buttons[BUTTON_RESET];
		end
	end

	always_comb begin
		control_next.up     = key_state.up    | joy0_q.up    | joy1_q.up;
		control_next.down   = key_state.down  | joy0_q.down  | joy1_q.down;
		control_next.left   = key_state.left  | joy0_q.left  | joy1_q.left;
		control_next.right  = key_state.right | joy0_q.right | joy1_q.right;
		control_next.fire   = key_state.fire1 | joy0_q.fire1 | joy1_q.fire1; // space
		control_next.bomb   = key_state.fire2 | joy0_q.fire2 | joy1_q.fire2; // alt
		control_next.coin   = key_state.coin;
		control_next.start1 = key_state.start1;
		control_next.start2 = key_state.start2;
	end

	always_ff @(posedge clk_20) begin
		if (reset)
			control <= '0;
		else
			control <= control_next;
	end

	// held one cycle past the end of reset
	always_ff @(posedge clk_20)
		game_reset <= reset | host_rst_q;

endmodule

// ==== hdl/sigma_delta_dac.sv ====
`timescale 1ns/1ns

module sigma_delta_dac (
	input  logic                              clk_20,
	input  logic                              reset,
	input  logic [arcade_io_pkg::AUDIO_W-1:0] sample,
	output logic                              audio_bit
);
	import arcade_io_pkg::*;

	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W:0]   sum;

	// carry out of the accumulator is the pulse density output
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_20) begin
		if (reset) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[AUDIO_W-1:0];
			audio_bit <= sum[AUDIO_W];
		end
	end

endmodule

// ==== hdl/arcade_io_top.sv ====
`timescale 1ns/1ns

module arcade_io_top (
	input  logic                              clk_20,
	input  logic                              reset,
	input  logic [arcade_io_pkg::ADDR_W-1:0]  paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [arcade_io_pkg::DATA_W-1:0]  pwdata,
	output logic [arcade_io_pkg::DATA_W-1:0]  prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic [arcade_io_pkg::AUDIO_W-1:0] audio_sample,
	output arcade_io_pkg::control_t           control,
	output logic                              game_reset,
	output logic                              audio_bit
);
	import arcade_io_pkg::*;

	logic [DATA_W-1:0]    status;
	joy_t                 joy0;
	joy_t                 joy1;
	logic [BUTTONS_W-1:0] buttons;
	key_event_t           key_event;
	key_state_t           key_state;

	host_regs u_regs (
		.clk_20    (clk_20),
		.reset     (reset),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.control   (control), // read back via REG_CONTROL
		.status    (status),
		.joy0      (joy0),
		.joy1      (joy1),
		.buttons   (buttons),
		.key_event (key_event)
	);

	key_decode u_keys (
		.clk_20    (clk_20),
		.reset     (reset),
		.key_event (key_event),
		.key_state (key_state)
	);

	control_merge u_merge (
		.clk_20     (clk_20),
		.reset      (reset),
		.key_state  (key_state),
		.joy0       (joy0),
		.joy1       (joy1),
		.status     (status),
		.buttons    (buttons),
		.control    (control),
		.game_reset (game_reset)
	);

	sigma_delta_dac u_dac (
		.clk_20    (clk_20),
		.reset     (reset),
		.sample    (audio_sample),
		.audio_bit (audio_bit)
	);

endmodule

// ==== bench/arcade_io_asserts.sv ====
`timescale 1ns/1ns

module arcade_io_asserts (
	input logic                             clk_20,
	input logic                             reset,
	input logic                             psel,
	input logic                             penable,
	input logic                             pready,
	input logic                             pslverr,
	input logic [arcade_io_pkg::DATA_W-1:0] prdata
);
	logic access;

	assign access = psel & penable;

	ready_in_access: assert property (@(posedge clk_20) disable iff (reset) access |-> pready)
		else $error("pready low in an access cycle");

	err_only_in_access: assert property (@(posedge clk_20) disable iff (reset)
		!access |-> !pslverr)
		else $error("pslverr high outside an access cycle");

	rdata_idle_zero: assert property (@(posedge clk_20) disable iff (reset)
		!access |-> (prdata == '0))
		else $error("prdata not zero outside an access cycle");

endmodule

bind host_regs arcade_io_asserts u_asserts (
	.clk_20  (clk_20),
	.reset   (reset),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.pslverr (pslverr),
	.prdata  (prdata)
);

// ==== bench/arcade_io_tb.sv ====
`timescale 1ns/1ns

module arcade_io_tb;
	import arcade_io_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	localparam int N_REG        = 24;
	localparam int N_KEY        = 48;
	localparam int N_JOY        = 24;
	localparam int AUDIO_CYCLES = 65536;
	localparam int OP_CYCLES    = 12; // bound for one transfer and its checks
	localparam int N_OPS        = 6 * N_REG + 6 * 8 + 2 * N_KEY + 2 * N_JOY + 40;
	localparam int WATCHDOG_CYCLES = 2 * (AUDIO_CYCLES + 4 * RESET_CYCLES)
		+ N_OPS * OP_CYCLES + 1000;

	logic                 clk_20;
	logic                 reset;
	logic [ADDR_W-1:0]    paddr;
	logic                 psel, penable, pwrite;
	logic [DATA_W-1:0]    pwdata;
	logic [DATA_W-1:0]    prdata;
	logic                 pready, pslverr;
	logic [AUDIO_W-1:0]   audio_sample;
	control_t             control;
	logic                 game_reset, audio_bit;

	logic [DATA_W-1:0]    m_status;
	joy_t                 m_joy0, m_joy1;
	logic [BUTTONS_W-1:0] m_buttons;
	key_state_t           m_keys;
	key_event_t           m_key_event;
	control_t             exp_ctrl_prev, exp_ctrl_next;
	logic                 exp_rst_prev, exp_rst_next;
	logic [31:0]          lfsr;
	logic [7:0]           key_table [16];
	event                 write_done, check_done;

	arcade_io_top uut (
		.clk_20       (clk_20),
		.reset        (reset),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.audio_sample (audio_sample),
		.control      (control),
		.game_reset   (game_reset),
		.audio_bit    (audio_bit)
	);

	always #(CLK_PERIOD / 2) clk_20 = ~clk_20;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic key_state_t apply_key(input key_state_t ks, input logic pressed,
		input logic [7:0] code);
		key_state_t n;
		n = ks;
		case (code)
			KEY_UP:    n.up = pressed;
			KEY_DOWN:  n.down = pressed;
			KEY_LEFT:  n.left = pressed;
			KEY_RIGHT: n.right = pressed;
			KEY_ESC:   n.coin = pressed;
			KEY_F1:    n.start1 = pressed;
			KEY_F2:    n.start2 = pressed;
			KEY_SPACE: n.fire1 = pressed;
			KEY_ALT:   n.fire2 = pressed;
			KEY_CTRL:  n.fire3 = pressed;
			default: ; // unmapped, no change
		endcase
		return n;
	endfunction

	function automatic control_t expected_control(input key_state_t ks, input joy_t j0,
		input joy_t j1);
		control_t c;
		c.up     = ks.up | j0.up | j1.up;
		c.down   = ks.down | j0.down | j1.down;
		c.left   = ks.left | j0.left | j1.left;
		c.right  = ks.right | j0.right | j1.right;
		c.fire   = ks.fire1 | j0.fire1 | j1.fire1;
		c.bomb   = ks.fire2 | j0.fire2 | j1.fire2;
		c.coin   = ks.coin;
		c.start1 = ks.start1;
		c.start2 = ks.start2;
		return c;
	endfunction

	function automatic logic expected_game_reset(input logic [DATA_W-1:0] st,
		input logic [BUTTONS_W-1:0] bt);
		return st[STATUS_RESET] | st[STATUS_MENU_RESET] | bt[BUTTON_RESET];
	endfunction

	task automatic check_control(input string name, input control_t got, input control_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output logic err);
		@(posedge clk_20);
		paddr   <= addr;
		pwdata  <= data;
		pwrite  <= 1'b1;
		psel    <= 1'b1;
		@(posedge clk_20);
		penable <= 1'b1;
		@(negedge clk_20);
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(posedge clk_20); // access edge, write lands here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output logic err);
		@(posedge clk_20);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		@(posedge clk_20);
		penable <= 1'b1;
		@(negedge clk_20);
		data = prdata;
		err  = pslverr;
		check_bit("pready", pready, 1'b1);
		@(posedge clk_20);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input string name,
		input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] data;
		logic              err;
		apb_read(addr, data, err);
		check_bit("pslverr", err, 1'b0);
		check_word(name, data, exp);
	endtask

	task automatic check_regs();
		read_check(REG_STATUS, "status", m_status);
		read_check(REG_JOY, "joy", {16'h0000, m_joy1, m_joy0});
		read_check(REG_BUTTONS, "buttons", DATA_W'(m_buttons));
		read_check(REG_KEY, "key_event", DATA_W'(m_key_event));
		read_check(REG_CONTROL, "control read", DATA_W'(expected_control(m_keys, m_joy0, m_joy1)));
		@(negedge clk_20);
		check_control("control", control, expected_control(m_keys, m_joy0, m_joy1));
		check_bit("game_reset", game_reset, expected_game_reset(m_status, m_buttons));
	endtask

	// write, update the model, then let the compare process check both edges
	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic err;
		exp_ctrl_prev = expected_control(m_keys, m_joy0, m_joy1);
		exp_rst_prev  = expected_game_reset(m_status, m_buttons);
		apb_write(addr, data, err);
		check_bit("pslverr", err, 1'b0);
		case (addr)
			REG_STATUS:  m_status = data;
			REG_BUTTONS: m_buttons = data[BUTTONS_W-1:0];
			REG_JOY: begin
				m_joy0 = joy_t'(data[7:0]);
				m_joy1 = joy_t'(data[15:8]);
			end
			REG_KEY: begin
				m_key_event.toggle  = ~m_key_event.toggle;
				m_key_event.pressed = data[8];
				m_key_event.code    = data[7:0];
				m_keys = apply_key(m_keys, data[8], data[7:0]);
			end
			default: ;
		endcase
		exp_ctrl_next = expected_control(m_keys, m_joy0, m_joy1);
		exp_rst_next  = expected_game_reset(m_status, m_buttons);
		-> write_done;
		@(check_done);
	endtask

	task automatic bad_access(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] data;
		logic              err;
		take_bits(32, data);
		apb_write(addr, data, err);
		check_bit("pslverr", err, 1'b1);
		if (addr != REG_CONTROL) begin
			apb_read(addr, data, err);
			check_bit("pslverr", err, 1'b1);
			check_word("prdata", data, '0);
		end
		check_regs();
	endtask

	// returns at the edge that first sees reset low
	task automatic apply_reset();
		@(posedge clk_20);
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_20);
		reset       <= 1'b0;
		m_status    = '0;
		m_joy0      = '0;
		m_joy1      = '0;
		m_buttons   = '0;
		m_keys      = '0;
		m_key_event = '0;
	endtask

	initial begin
		forever begin
			@(write_done);
			@(posedge clk_20);
			@(negedge clk_20);
			check_control("control", control, exp_ctrl_prev); // one edge is too early
			check_bit("game_reset", game_reset, exp_rst_prev);
			@(posedge clk_20);
			@(negedge clk_20);
			check_control("control", control, exp_ctrl_next);
			check_bit("game_reset", game_reset, exp_rst_next);
			-> check_done;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] sel;
		logic [31:0] val;
		logic [31:0] ones;
		clk_20       = 1'b0;
		reset        = 1'b1;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		audio_sample = '0;
		lfsr         = 32'h43a5_cd21;
		key_table    = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_ESC, KEY_F1, KEY_F2,
			KEY_CTRL, KEY_ALT, KEY_SPACE, 8'h1C, 8'h00, 8'hF0, 8'h5A, 8'h16, 8'hE0};

		apply_reset();
		@(negedge clk_20);
		check_bit("game_reset", game_reset, 1'b1); // held one cycle past reset
		check_control("control", control, '0);
		check_bit("audio_bit", audio_bit, 1'b0);
		check_word("prdata", prdata, '0);
		check_bit("pslverr", pslverr, 1'b0);
		@(posedge clk_20);
		@(negedge clk_20);
		check_bit("game_reset", game_reset, 1'b0);

		// register read-back
		check_regs();
		for (int i = 0; i < N_REG; i++) begin
			take_bits(2, sel);
			take_bits(32, val);
			case (sel[1:0])
				2'd0:    host_write(REG_STATUS, val);
				2'd1:    host_write(REG_JOY, val);
				default: host_write(REG_BUTTONS, val);
			endcase
			check_regs();
		end
		bad_access(8'h14);
		bad_access(8'h02);
		bad_access(8'h40);
		bad_access(8'hFC);
		bad_access(REG_CONTROL);

		// keyboard decode
		host_write(REG_STATUS, '0);
		host_write(REG_JOY, '0);
		host_write(REG_BUTTONS, '0);
		for (int i = 0; i < N_KEY; i++) begin
			take_bits(4, sel);
			take_bits(1, val);
			host_write(REG_KEY, {23'b0, val[0], key_table[sel[3:0]]});
			read_check(REG_KEY, "key_event", DATA_W'(m_key_event));
		end
		host_write(REG_KEY, {23'b0, 1'b1, KEY_LEFT});
		host_write(REG_KEY, {23'b0, 1'b1, KEY_LEFT});
		host_write(REG_KEY, {23'b0, 1'b0, KEY_LEFT});
		host_write(REG_KEY, {23'b0, 1'b0, KEY_LEFT});

		// joystick merge with some keys held
		host_write(REG_KEY, {23'b0, 1'b1, KEY_UP});
		host_write(REG_KEY, {23'b0, 1'b1, KEY_SPACE});
		for (int i = 0; i < N_JOY; i++) begin
			take_bits(16, val);
			host_write(REG_JOY, {16'h0000, val[15:0]});
			read_check(REG_CONTROL, "control read",
				DATA_W'(expected_control(m_keys, m_joy0, m_joy1)));
		end

		// game reset sources, one at a time
		host_write(REG_STATUS, '0);
		host_write(REG_BUTTONS, '0);
		host_write(REG_STATUS, 32'hFFFF_FFBE); // every bit but the two reset bits
		host_write(REG_STATUS, 32'h1 << STATUS_RESET);
		host_write(REG_STATUS, '0);
		host_write(REG_STATUS, 32'h1 << STATUS_MENU_RESET);
		host_write(REG_STATUS, '0);
		host_write(REG_BUTTONS, DATA_W'(1) << BUTTON_RESET);
		host_write(REG_BUTTONS, '0);

		// audio density, fresh reset per sample
		for (int k = 0; k < 2; k++) begin
			take_bits(16, val);
			@(posedge clk_20);
			audio_sample <= val[15:0];
			apply_reset();
			ones = '0;
			repeat (AUDIO_CYCLES) begin
				@(posedge clk_20);
				@(negedge clk_20);
				if (audio_bit)
					ones = ones + 1;
			end
			check_word("audio ones", ones, DATA_W'(val[15:0]));
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== arcade_io_top.f ====
hdl/arcade_io_pkg.sv
hdl/host_regs.sv
hdl/key_decode.sv
hdl/control_merge.sv
hdl/sigma_delta_dac.sv
hdl/arcade_io_top.sv
bench/arcade_io_asserts.sv
bench/arcade_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the arcade_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir \
	--top-module arcade_io_tb -f arcade_io_top.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Varcade_io_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0
